//--- dct_macros.svh
`ifndef DCT_MACROS_SVH
`define DCT_MACROS_SVH

// frame geometry in samples and blocks
`define FRAME_WIDTH     320
`define BLOCK_ROWS      30
`define BLOCK_COLS      40

// side of one square block
`define BLOCK_DIM       8

// cycles from sram address to read data
`define SRAM_LATENCY    2

// lowest product bit that reaches the accumulator
`define PRODUCT_SHIFT   8

`define SRAM_ADDR_W     18

`endif

//--- dct_pkg.sv
`default_nettype none

package dct_pkg;

    typedef logic signed [15:0] sample_t;
    typedef logic signed [15:0] coef_t;
    typedef logic signed [31:0] product_t;
    typedef logic signed [31:0] result_t;

    typedef logic [5:0] buf_addr_t;     // row * 8 + column
    typedef logic [4:0] block_row_t;
    typedef logic [5:0] block_col_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_COMPUTE,
        ST_DRAIN
    } ctrl_state_e;

    // scaled cosine matrix, indexed [k][j]
    localparam coef_t C_TABLE [8][8] = '{
        '{ 16'sd1448,  16'sd1448,  16'sd1448,  16'sd1448,
           16'sd1448,  16'sd1448,  16'sd1448,  16'sd1448},
        '{ 16'sd2008,  16'sd1702,  16'sd1137,  16'sd399,
          -16'sd399,  -16'sd1137, -16'sd1702, -16'sd2008},
        '{ 16'sd1892,  16'sd783,  -16'sd783,  -16'sd1892,
          -16'sd1892, -16'sd783,   16'sd783,   16'sd1892},
        '{ 16'sd1702, -16'sd399,  -16'sd2008, -16'sd1137,
           16'sd1137,  16'sd2008,  16'sd399,  -16'sd1702},
        '{ 16'sd1448, -16'sd1448, -16'sd1448,  16'sd1448,
           16'sd1448, -16'sd1448, -16'sd1448,  16'sd1448},
        '{ 16'sd1137, -16'sd2008,  16'sd399,   16'sd1702,
          -16'sd1702, -16'sd399,   16'sd2008, -16'sd1137},
        '{ 16'sd783,  -16'sd1892,  16'sd1892, -16'sd783,
          -16'sd783,   16'sd1892, -16'sd1892,  16'sd783},
        '{ 16'sd399,  -16'sd1137,  16'sd1702, -16'sd2008,
           16'sd2008, -16'sd1702,  16'sd1137, -16'sd399}
    };

endpackage

`default_nettype wire

//--- dct_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sample_buf_if;
    import dct_pkg::*;

    logic      wr_en;
    buf_addr_t wr_addr;
    sample_t   wr_data;

    buf_addr_t rd_addr_a;
    buf_addr_t rd_addr_b;
    sample_t   rd_data_a;   // one cycle after rd_addr_a
    sample_t   rd_data_b;

    modport fetch  (output wr_en, wr_addr, wr_data);
    modport reader (output rd_addr_a, rd_addr_b, input rd_data_a, rd_data_b);
    modport store  (input wr_en, wr_addr, wr_data, rd_addr_a, rd_addr_b,
                    output rd_data_a, rd_data_b);
endinterface

interface tile_if;
    import dct_pkg::*;

    logic       tile_valid;     // one cycle, data valid alongside
    logic [2:0] tile_row;       // even row i
    logic [2:0] tile_col;       // even column j
    result_t    t_aa;
    result_t    t_ab;
    result_t    t_ba;
    result_t    t_bb;

    modport source (output tile_valid, tile_row, tile_col, t_aa, t_ab, t_ba, t_bb);
    modport sink   (input tile_valid, tile_row, tile_col, t_aa, t_ab, t_ba, t_bb);
endinterface

`default_nettype wire

//--- block_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "dct_macros.svh"

module block_fetch (
    input  wire logic                      CLOCK,
    input  wire logic                      Resetn,
    input  wire logic                      start,
    input  wire dct_pkg::block_row_t       block_row,
    input  wire dct_pkg::block_col_t       block_col,
    output logic [`SRAM_ADDR_W-1:0]        sram_address,
    output logic                           sram_read_en,
    input  wire dct_pkg::sample_t          sram_read_data,
    sample_buf_if.fetch                    buf_wr,
    output logic                           busy,
    output logic                           fetch_done,
    input  wire logic                      block_end
);
    import dct_pkg::*;

    // 320 = 256 + 64, so a frame row is two shifted copies
    localparam int ROW_SHIFT_HI = $clog2(`FRAME_WIDTH) - 1;
    localparam int ROW_SHIFT_LO = $clog2(`FRAME_WIDTH - (1 << ROW_SHIFT_HI));
    localparam buf_addr_t LAST_IDX = buf_addr_t'(`BLOCK_DIM * `BLOCK_DIM - 1);

    ctrl_state_e state;
    buf_addr_t   fetch_cnt;     // r in [5:3], c in [2:0]
    block_row_t  blk_row;
    block_col_t  blk_col;

    logic [`SRAM_ADDR_W-1:0] frame_row;
    logic [`SRAM_ADDR_W-1:0] frame_col;

    logic      dly_valid [`SRAM_LATENCY];
    buf_addr_t dly_idx   [`SRAM_LATENCY];

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            state     <= ST_IDLE;
            fetch_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_FETCH;
                        fetch_cnt <= '0;
                    end
                end
                ST_FETCH: begin
                    fetch_cnt <= fetch_cnt + 1'b1;
                    if (fetch_cnt == LAST_IDX)
                        state <= ST_DRAIN;   // reads still in flight
                end
                ST_DRAIN: begin
                    if (fetch_done)
                        state <= ST_COMPUTE;
                end
                ST_COMPUTE: begin
                    if (block_end)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // out of range coordinates clamp to the last block
    always_ff @(posedge CLOCK) begin
        if (state == ST_IDLE && start) begin
            blk_row <= (block_row < `BLOCK_ROWS) ? block_row : block_row_t'(`BLOCK_ROWS - 1);
            blk_col <= (block_col < `BLOCK_COLS) ? block_col : block_col_t'(`BLOCK_COLS - 1);
        end
    end

    assign frame_row    = `SRAM_ADDR_W'({blk_row, fetch_cnt[5:3]});
    assign frame_col    = `SRAM_ADDR_W'({blk_col, fetch_cnt[2:0]});
    assign sram_address = (frame_row << ROW_SHIFT_HI) + (frame_row << ROW_SHIFT_LO) + frame_col;
    assign sram_read_en = (state == ST_FETCH);
    assign busy         = (state != ST_IDLE);

    // index and valid follow the sram read latency
    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            for (int i = 0; i < `SRAM_LATENCY; i++)
                dly_valid[i] <= 1'b0;
        end else begin
            dly_valid[0] <= sram_read_en;
            for (int i = 1; i < `SRAM_LATENCY; i++)
                dly_valid[i] <= dly_valid[i-1];
        end
    end

    always_ff @(posedge CLOCK) begin
        dly_idx[0] <= fetch_cnt;
        for (int i = 1; i < `SRAM_LATENCY; i++)
            dly_idx[i] <= dly_idx[i-1];
    end

    assign buf_wr.wr_en   = dly_valid[`SRAM_LATENCY-1];
    assign buf_wr.wr_addr = dly_idx[`SRAM_LATENCY-1];
    assign buf_wr.wr_data = sram_read_data;
    assign fetch_done     = buf_wr.wr_en && (buf_wr.wr_addr == LAST_IDX);

endmodule

`default_nettype wire

//--- sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_buffer (
    input  wire logic   CLOCK,
    sample_buf_if.store bus
);
    import dct_pkg::*;

    sample_t mem [64];

    always_ff @(posedge CLOCK) begin
        if (bus.wr_en)
            mem[bus.wr_addr] <= bus.wr_data;
    end

    // two rows per cycle, both ports registered
    always_ff @(posedge CLOCK) begin
        bus.rd_data_a <= mem[bus.rd_addr_a];
        bus.rd_data_b <= mem[bus.rd_addr_b];
    end

endmodule

`default_nettype wire

//--- tile_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "dct_macros.svh"

module tile_mac (
    input  wire logic    CLOCK,
    input  wire logic    Resetn,
    input  wire logic    fetch_done,
    sample_buf_if.reader buf_rd,
    tile_if.source       tile
);
    import dct_pkg::*;

    localparam int K_W       = $clog2(`BLOCK_DIM);
    localparam int T_W       = K_W - 1;
    localparam int K_LAST    = `BLOCK_DIM - 1;
    localparam int TILE_LAST = `BLOCK_DIM / 2 - 1;
    localparam int TAG_W     = 2 * T_W + K_W;

    logic           running;
    logic [T_W-1:0] ti;         // tile row, i = 2 * ti
    logic [T_W-1:0] tj;         // tile column, j = 2 * tj
    logic [K_W-1:0] k;

    // pipeline tags {ti, tj, k}
    logic             v1, v2, v3;
    logic [TAG_W-1:0] tag1, tag2, tag3;

    sample_t  op   [2];         // rows i and i+1
    coef_t    cop  [2];         // columns j and j+1
    product_t prod [2][2];
    result_t  acc  [2][2];

    // bits 23..8 of a product, sign extended
    function automatic result_t contrib(input product_t p);
        sample_t s;
        s = p[`PRODUCT_SHIFT +: $bits(sample_t)];
        return result_t'(s);
    endfunction

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            running <= 1'b0;
            ti      <= '0;
            tj      <= '0;
            k       <= '0;
        end else if (fetch_done) begin
            running <= 1'b1;
            ti      <= '0;
            tj      <= '0;
            k       <= '0;
        end else if (running) begin
            k <= k + 1'b1;
            if (k == K_LAST) begin
                tj <= tj + 1'b1;
                if (tj == TILE_LAST) begin
                    ti <= ti + 1'b1;
                    if (ti == TILE_LAST)
                        running <= 1'b0;    // last k step of tile 15
                end
            end
        end
    end

    assign buf_rd.rd_addr_a = {ti, 1'b0, k};
    assign buf_rd.rd_addr_b = {ti, 1'b1, k};

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            v1              <= 1'b0;
            v2              <= 1'b0;
            v3              <= 1'b0;
            tile.tile_valid <= 1'b0;
        end else begin
            v1              <= running;
            v2              <= v1;
            v3              <= v2;
            tile.tile_valid <= v3 && (tag3[K_W-1:0] == K_LAST);
        end
    end

    always_ff @(posedge CLOCK) begin
        tag1 <= {ti, tj, k};
        tag2 <= tag1;
        tag3 <= tag2;

        // operand stage, C looked up with the k of the read
        op[0]  <= buf_rd.rd_data_a;
        op[1]  <= buf_rd.rd_data_b;
        cop[0] <= C_TABLE[tag1[K_W-1:0]][{tag1[K_W +: T_W], 1'b0}];
        cop[1] <= C_TABLE[tag1[K_W-1:0]][{tag1[K_W +: T_W], 1'b1}];

        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 2; c++) begin
                prod[r][c] <= op[r] * cop[c];
                if (v3) begin
                    if (tag3[K_W-1:0] == '0)
                        acc[r][c] <= contrib(prod[r][c]);   // first k of the tile
                    else
                        acc[r][c] <= acc[r][c] + contrib(prod[r][c]);
                end
            end
        end

        if (v3 && (tag3[K_W-1:0] == K_LAST)) begin
            tile.tile_row <= {tag3[K_W+T_W +: T_W], 1'b0};
            tile.tile_col <= {tag3[K_W +: T_W], 1'b0};
        end
    end

    // held for one cycle before k = 0 of the next tile lands
    assign tile.t_aa = acc[0][0];
    assign tile.t_ab = acc[0][1];
    assign tile.t_ba = acc[1][0];
    assign tile.t_bb = acc[1][1];

endmodule

`default_nettype wire

//--- result_stream.sv
`timescale 1ns/1ps
`default_nettype none

module result_stream (
    input  wire logic          CLOCK,
    input  wire logic          Resetn,
    tile_if.sink               tile,
    output logic               t_valid,
    output dct_pkg::buf_addr_t t_index,
    output dct_pkg::result_t   t_data,
    output logic               done,
    output logic               block_end
);
    import dct_pkg::*;

    logic       active;
    logic [1:0] beat;           // aa, ab, ba, bb
    logic [3:0] tile_cnt;
    logic [2:0] hold_row;
    logic [2:0] hold_col;
    result_t    hold [4];

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            active   <= 1'b0;
            beat     <= '0;
            tile_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= block_end;
            if (tile.tile_valid) begin
                active <= 1'b1;
                beat   <= '0;
            end else if (active) begin
                beat <= beat + 1'b1;
                if (beat == 2'd3) begin
                    active   <= 1'b0;
                    tile_cnt <= tile_cnt + 1'b1;   // wraps after 16 tiles
                end
            end
        end
    end

    always_ff @(posedge CLOCK) begin
        if (tile.tile_valid) begin
            hold_row <= tile.tile_row;
            hold_col <= tile.tile_col;
            hold[0]  <= tile.t_aa;
            hold[1]  <= tile.t_ab;
            hold[2]  <= tile.t_ba;
            hold[3]  <= tile.t_bb;
        end
    end

    assign t_valid   = active;
    assign t_data    = hold[beat];
    assign t_index   = {hold_row + 3'(beat[1]), hold_col + 3'(beat[0])};
    assign block_end = active && (beat == 2'd3) && (&tile_cnt);

endmodule

`default_nettype wire

//--- idct_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dct_macros.svh"

module idct_top (
    input  wire logic                CLOCK,
    input  wire logic                Resetn,
    input  wire logic                start,
    input  wire dct_pkg::block_row_t block_row,
    input  wire dct_pkg::block_col_t block_col,
    output logic [`SRAM_ADDR_W-1:0]  sram_address,
    output logic                     sram_read_en,
    input  wire dct_pkg::sample_t    sram_read_data,
    output logic                     t_valid,
    output dct_pkg::buf_addr_t       t_index,
    output dct_pkg::result_t         t_data,
    output logic                     busy,
    output logic                     done
);

    logic fetch_done;
    logic block_end;

    sample_buf_if buf_bus ();
    tile_if       tile_bus ();

    block_fetch i_block_fetch (
        .CLOCK          (CLOCK),
        .Resetn         (Resetn),
        .start          (start),
        .block_row      (block_row),
        .block_col      (block_col),
        .sram_address   (sram_address),
        .sram_read_en   (sram_read_en),
        .sram_read_data (sram_read_data),
        .buf_wr         (buf_bus.fetch),
        .busy           (busy),
        .fetch_done     (fetch_done),
        .block_end      (block_end)
    );

    sample_buffer i_sample_buffer (
        .CLOCK (CLOCK),
        .bus   (buf_bus.store)
    );

    tile_mac i_tile_mac (
        .CLOCK      (CLOCK),
        .Resetn     (Resetn),
        .fetch_done (fetch_done),
        .buf_rd     (buf_bus.reader),
        .tile       (tile_bus.source)
    );

    result_stream i_result_stream (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .tile      (tile_bus.sink),
        .t_valid   (t_valid),
        .t_index   (t_index),
        .t_data    (t_data),
        .done      (done),
        .block_end (block_end)
    );

endmodule

`default_nettype wire

//--- tb_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dct_macros.svh"

module tb_sram (
    input  wire logic                    CLOCK,
    input  wire logic [`SRAM_ADDR_W-1:0] address,
    input  wire logic                    read_en,
    output dct_pkg::sample_t             read_data
);
    import dct_pkg::*;

    sample_t mem  [2**`SRAM_ADDR_W];
    sample_t pipe [`SRAM_LATENCY];      // one stage per cycle of read latency

    initial begin
        for (int i = 0; i < `SRAM_LATENCY; i++)
            pipe[i] = '0;
    end

    always @(posedge CLOCK) begin
        pipe[0] <= read_en ? mem[address] : '0;
        for (int i = 1; i < `SRAM_LATENCY; i++)
            pipe[i] <= pipe[i-1];
    end

    assign read_data = pipe[`SRAM_LATENCY-1];

    task automatic load(input logic [`SRAM_ADDR_W-1:0] a, input sample_t d);
        mem[a] = d;
    endtask

endmodule

`default_nettype wire

//--- tb_idct.sv
`timescale 1ns/1ps
`default_nettype none

`include "dct_macros.svh"

module tb_idct;
    import dct_pkg::*;

    typedef enum logic [1:0] {FILL_ZERO, FILL_CONST, FILL_LFSR, FILL_IMPULSE} fill_e;

    typedef struct packed {
        block_row_t row;
        block_col_t col;
        fill_e      fill;
        sample_t    value;      // constant or impulse height
        buf_addr_t  pos;        // impulse position r * 8 + c
        logic       restart;    // pulse start again while busy
        logic [6:0] beats;
    } stim_t;

    localparam int NUM_STIM    = 7;
    localparam int CYCLE_LIMIT = NUM_STIM * 300 + 50;

    localparam stim_t STIM [NUM_STIM] = '{
        '{5'd0,  6'd0,  FILL_ZERO,    16'sd0,      6'd0,  1'b0, 7'd64},
        '{5'd29, 6'd39, FILL_CONST,   16'sd1000,   6'd0,  1'b0, 7'd64},
        '{5'd12, 6'd17, FILL_LFSR,    16'sd0,      6'd0,  1'b1, 7'd64},
        '{5'd0,  6'd39, FILL_IMPULSE, -16'sd20000, 6'd27, 1'b0, 7'd64},
        '{5'd29, 6'd0,  FILL_LFSR,    16'sd0,      6'd0,  1'b0, 7'd64},
        '{5'd7,  6'd21, FILL_CONST,   16'sh8000,   6'd0,  1'b1, 7'd64},
        '{5'd29, 6'd39, FILL_IMPULSE, 16'sd32767,  6'd0,  1'b0, 7'd64}
    };

    logic                    CLOCK;
    logic                    Resetn;
    logic                    start;
    block_row_t              block_row;
    block_col_t              block_col;
    logic [`SRAM_ADDR_W-1:0] sram_address;
    logic                    sram_read_en;
    sample_t                 sram_read_data;
    logic                    t_valid;
    buf_addr_t               t_index;
    result_t                 t_data;
    logic                    busy;
    logic                    done;

    logic [31:0]             lfsr = 32'h4767_8321;
    int                      cycle_cnt;
    logic [`SRAM_ADDR_W-1:0] exp_addr [64];
    result_t                 exp_t    [64];

    idct_top i_idct_top (.*);

    tb_sram i_sram (
        .CLOCK     (CLOCK),
        .address   (sram_address),
        .read_en   (sram_read_en),
        .read_data (sram_read_data)
    );

    initial begin
        CLOCK = 1'b0;
        forever #4 CLOCK = ~CLOCK;
    end

    always @(posedge CLOCK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            abort_run("timeout: the table did not finish within the cycle limit");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_result(input string name, input result_t act, input result_t exp);
        if (act !== exp)
            abort_run($sformatf("ERR %s: got %h, expected %h", name, act, exp));
    endtask

    task automatic check_index(input string name, input buf_addr_t act, input buf_addr_t exp);
        if (act !== exp)
            abort_run($sformatf("ERR %s: got %h, expected %h", name, act, exp));
    endtask

    task automatic check_address(input string name, input logic [`SRAM_ADDR_W-1:0] act,
                                 input logic [`SRAM_ADDR_W-1:0] exp);
        if (act !== exp)
            abort_run($sformatf("ERR %s: got %h, expected %h", name, act, exp));
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic lfsr_word(output sample_t w);
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_next(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    // every address bit shows up in the word
    task automatic fill_background();
        for (int a = 0; a < 2**`SRAM_ADDR_W; a++)
            i_sram.load(a[`SRAM_ADDR_W-1:0], sample_t'(a[15:0] ^ {a[17:16], 14'h1e5b}));
    endtask

    // writes the block into the sram and works out addresses and T
    task automatic prepare_block(input stim_t s);
        sample_t  blk [8][8];
        sample_t  part;
        product_t p;
        result_t  acc;
        int       a;
        for (int r = 0; r < `BLOCK_DIM; r++) begin
            for (int c = 0; c < `BLOCK_DIM; c++) begin
                a = (s.row * `BLOCK_DIM + r) * `FRAME_WIDTH + s.col * `BLOCK_DIM + c;
                exp_addr[r*8+c] = a[`SRAM_ADDR_W-1:0];
                case (s.fill)
                    FILL_ZERO:  blk[r][c] = '0;
                    FILL_CONST: blk[r][c] = s.value;
                    FILL_LFSR:  lfsr_word(blk[r][c]);
                    default:    blk[r][c] = (r * 8 + c == s.pos) ? s.value : '0;
                endcase
                i_sram.load(exp_addr[r*8+c], blk[r][c]);
            end
        end
        for (int i = 0; i < `BLOCK_DIM; i++) begin
            for (int j = 0; j < `BLOCK_DIM; j++) begin
                acc = '0;
                for (int k = 0; k < `BLOCK_DIM; k++) begin
                    p    = blk[i][k] * C_TABLE[k][j];
                    part = sample_t'(p >>> `PRODUCT_SHIFT);   // bits 23..8
                    acc  = acc + result_t'(part);
                end
                exp_t[i*8+j] = acc;
            end
        end
    endtask

    // tiles row by row with beats aa, ab, ba, bb
    function automatic buf_addr_t beat_index(input int n);
        int tile;
        tile = n / 4;
        return buf_addr_t'(((tile / 4) * 2 + (n % 4) / 2) * 8 + (tile % 4) * 2 + n % 2);
    endfunction

    task automatic run_block(input stim_t s);
        int   reads;
        int   beats;
        int   step;
        reads = 0;
        beats = 0;
        step  = 0;
        if (busy)
            abort_run("busy is high before start");
        do begin
            @(posedge CLOCK);
            #1;
            start = (step == 0) || (s.restart && (step == 30 || step == 120));
            if (step == 0) begin
                block_row = s.row;
                block_col = s.col;
            end else if (start) begin
                block_row = 5'd3;   // a block that must not be fetched
                block_col = 6'd9;
            end
            step++;
            @(negedge CLOCK);
            if (step > 1 && !done && !busy)
                abort_run("busy is low between start and done");
            if (sram_read_en) begin
                if (reads == 64)
                    abort_run("sram_read_en is high for more than 64 cycles");
                check_address("sram_address", sram_address, exp_addr[reads]);
                reads++;
            end
            if (t_valid) begin
                if (beats == 64)
                    abort_run("more than 64 stream beats in one block");
                check_index("t_index", t_index, beat_index(beats));
                check_result("t_data", t_data, exp_t[t_index]);
                beats++;
            end
        end while (!done);
        if (reads != 64)
            abort_run($sformatf("%0d SRAM reads in the block instead of 64", reads));
        if (beats != int'(s.beats))
            abort_run("done came before all stream beats of the block");
        if (busy)
            abort_run("busy is still high in the done cycle");
        @(negedge CLOCK);
        if (done || busy)
            abort_run("done or busy is high in the cycle after done");
    endtask

    initial begin
        Resetn    = 1'b0;
        start     = 1'b0;
        block_row = '0;
        block_col = '0;
        fill_background();
        repeat (10) @(posedge CLOCK);
        #1;
        Resetn = 1'b1;
        repeat (20) begin
            @(negedge CLOCK);
            if (sram_read_en || t_valid || busy || done)
                abort_run("an output went high after reset without a start");
        end
        for (int n = 0; n < NUM_STIM; n++) begin
            prepare_block(STIM[n]);
            run_block(STIM[n]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
dct_pkg.sv
dct_if.sv
block_fetch.sv
sample_buffer.sv
tile_mac.sv
result_stream.sv
idct_top.sv
tb_sram.sv
tb_idct.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
LINTFLAGS = --lint-only -Wall
TOP       = tb_idct
RTL_TOP   = idct_top
FLIST     = flist.f
PASS      = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
